//--- exec_cluster.f
hw/exec_pkg.sv
hw/op_dispatch.sv
hw/alu_lane.sv
hw/result_merge.sv
hw/exec_cluster.sv
verif/exec_cluster_checker.sv
verif/exec_cluster_tb.sv

//--- hw/alu_lane.sv
`timescale 1ns/10ps

module alu_lane (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  exec_pkg::lane_req_t issue_req,
    output logic                busy,
    output logic                res_valid,
    output exec_pkg::lane_res_t res
);
    import exec_pkg::*;

    exec_req_t            r;
    lane_res_t            nxt_res;
    lane_res_t            mul_hold;
    logic [MUL_CNT_W-1:0] mul_cnt;
    logic                 is_mul;

    assign r      = issue_req.req;
    assign is_mul = (r.opcode == OP_ALU) && (r.funct7 == F7_MUL);
    assign busy   = (mul_cnt != '0);

    always_comb begin
        nxt_res              = '0;
        nxt_res.tag          = issue_req.tag;
        nxt_res.target_pc    = r.pc + r.immediate;  // Branch target for every op
        nxt_res.alu_out      = '0;
        nxt_res.branch_taken = 1'b0;

        case (r.opcode)
            OP_ALU: begin
                case (r.funct7)
                    F7_SUB: nxt_res.alu_out = r.operand1 - r.operand2;
                    F7_MUL: nxt_res.alu_out = r.operand1 * r.operand2;  // Low word only
                    F7_BASE: begin
                        case (r.funct3)
                            F3_ADD:  nxt_res.alu_out = r.operand1 + r.operand2;
                            F3_AND:  nxt_res.alu_out = r.operand1 & r.operand2;
                            F3_OR:   nxt_res.alu_out = r.operand1 | r.operand2;
                            default: nxt_res.alu_out = '0;
                        endcase
                    end
                    F7_MOVRM: nxt_res.alu_out = r.rm1;  // Privileged reg to GPR
                    default:  nxt_res.alu_out = '0;
                endcase
            end
            OP_ALUI: begin
                // Shift amount is the whole immediate, so 32 and up clears
                case (r.funct3)
                    F3_ADDI: nxt_res.alu_out = r.operand1 + r.immediate;
                    F3_SLLI: nxt_res.alu_out = r.operand1 << r.immediate;
                    F3_SRLI: nxt_res.alu_out = r.operand1 >> r.immediate;
                    default: nxt_res.alu_out = '0;
                endcase
            end
            OP_AUIPC: nxt_res.alu_out = r.pc + r.immediate;
            OP_LUI:   nxt_res.alu_out = r.immediate;
            OP_BRANCH: begin
                // Unsigned compares; difference goes out as alu_out
                case (r.funct3)
                    F3_BEQ: begin
                        nxt_res.branch_taken = (r.operand1 == r.operand2);
                        nxt_res.alu_out      = r.operand1 - r.operand2;
                    end
                    F3_BNE: begin
                        nxt_res.branch_taken = (r.operand1 != r.operand2);
                        nxt_res.alu_out      = r.operand1 - r.operand2;
                    end
                    F3_BLT: begin
                        nxt_res.branch_taken = (r.operand1 < r.operand2);
                        nxt_res.alu_out      = r.operand1 - r.operand2;
                    end
                    F3_BGE: begin
                        nxt_res.branch_taken = (r.operand1 >= r.operand2);
                        nxt_res.alu_out      = r.operand1 - r.operand2;
                    end
                    default: nxt_res.alu_out = '0;
                endcase
            end
            OP_JUMP:  nxt_res.branch_taken = 1'b1;  // Unconditional
            OP_LOAD:  nxt_res.alu_out = r.operand1 + r.immediate;  // Memory address
            OP_STORE: nxt_res.alu_out = r.operand1 + r.immediate;
            OP_SYSTEM: begin
                case (r.funct3)
                    F3_IRET:     nxt_res.alu_out = '0;
                    F3_MOVRM:    nxt_res.alu_out = r.operand1;
                    F3_TLBWRITE: nxt_res.alu_out = '0;
                    default:     nxt_res.alu_out = '0;
                endcase
            end
            default: begin
                nxt_res.alu_out      = '0;
                nxt_res.branch_taken = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_cnt   <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= (issue_valid && !is_mul) || (mul_cnt == MUL_CNT_W'(1));
            if (issue_valid && is_mul) begin
                mul_cnt <= MUL_CNT_W'(MUL_LATENCY - 1);  // Issue edge counts as the first
            end else if (mul_cnt != '0) begin
                mul_cnt <= mul_cnt - 1'b1;
            end
        end
    end

    // Single-cycle ops and the finished MUL share the result register
    always_ff @(posedge clk) begin
        if (issue_valid && is_mul) begin
            mul_hold <= nxt_res;
        end
        if (issue_valid && !is_mul) begin
            res <= nxt_res;
        end else if (mul_cnt == MUL_CNT_W'(1)) begin
            res <= mul_hold;
        end
    end

endmodule

//--- hw/exec_cluster.sv
`timescale 1ns/10ps

module exec_cluster (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  exec_pkg::exec_req_t in_req,
    output logic                stall,
    output logic                out_valid,
    output exec_pkg::retire_t   out_res
);
    import exec_pkg::*;

    logic [NUM_LANES-1:0] issue_valid;
    lane_req_t            issue_req;
    logic [NUM_LANES-1:0] busy;
    logic [NUM_LANES-1:0] res_valid;
    lane_res_t            res [NUM_LANES];

    op_dispatch i_op_dispatch (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .busy        (busy),
        .retire      (out_valid),   // Frees one outstanding slot
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue_req   (issue_req)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        alu_lane i_alu_lane (
            .clk         (clk),
            .reset       (reset),
            .issue_valid (issue_valid[i]),
            .issue_req   (issue_req),     // Shared, only the strobed lane takes it
            .busy        (busy[i]),
            .res_valid   (res_valid[i]),
            .res         (res[i])
        );
    end

    result_merge i_result_merge (
        .clk       (clk),
        .reset     (reset),
        .res_valid (res_valid),
        .res       (res),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

endmodule

//--- hw/exec_pkg.sv
package exec_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_LANES   = 4;
    localparam int LANE_W      = $clog2(NUM_LANES);
    localparam int TAG_W       = 4;
    localparam int ROB_DEPTH   = 1 << TAG_W;           // One entry per tag value
    localparam int MUL_LATENCY = 3;
    localparam int MUL_CNT_W   = $clog2(MUL_LATENCY);

    // Major opcodes
    localparam logic [6:0] OP_ALU    = 7'b0110011;
    localparam logic [6:0] OP_ALUI   = 7'b0010011;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JUMP   = 7'b1101111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Funct7 selects within OP_ALU
    localparam logic [6:0] F7_BASE  = 7'b0000000;
    localparam logic [6:0] F7_SUB   = 7'b0100000;
    localparam logic [6:0] F7_MUL   = 7'b0000001;
    localparam logic [6:0] F7_MOVRM = 7'b1000000;

    localparam logic [2:0] F3_ADD      = 3'b000;
    localparam logic [2:0] F3_AND      = 3'b111;
    localparam logic [2:0] F3_OR       = 3'b110;
    localparam logic [2:0] F3_ADDI     = 3'b000;
    localparam logic [2:0] F3_SLLI     = 3'b001;
    localparam logic [2:0] F3_SRLI     = 3'b101;
    localparam logic [2:0] F3_BEQ      = 3'b000;
    localparam logic [2:0] F3_BNE      = 3'b001;
    localparam logic [2:0] F3_BLT      = 3'b100;
    localparam logic [2:0] F3_BGE      = 3'b101;
    localparam logic [2:0] F3_IRET     = 3'b000;
    localparam logic [2:0] F3_MOVRM    = 3'b001;
    localparam logic [2:0] F3_TLBWRITE = 3'b111;

    // Decoded instruction as it enters the cluster
    typedef struct packed {
        logic [6:0]      opcode;
        logic [2:0]      funct3;
        logic [6:0]      funct7;
        logic [XLEN-1:0] operand1;
        logic [XLEN-1:0] operand2;
        logic [XLEN-1:0] immediate;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rm1;
    } exec_req_t;

    typedef struct packed {
        exec_req_t        req;
        logic [TAG_W-1:0] tag;
    } lane_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  alu_out;
        logic [XLEN-1:0]  target_pc;
        logic             branch_taken;
    } lane_res_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] target_pc;
        logic            branch_taken;
    } retire_t;

endpackage

//--- hw/op_dispatch.sv
`timescale 1ns/10ps

module op_dispatch (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  exec_pkg::exec_req_t                in_req,
    input  logic [exec_pkg::NUM_LANES-1:0]     busy,
    input  logic                               retire,
    output logic                               stall,
    output logic [exec_pkg::NUM_LANES-1:0]     issue_valid,
    output exec_pkg::lane_req_t                issue_req
);
    import exec_pkg::*;

    logic [TAG_W-1:0]     tag_cnt;
    logic [TAG_W:0]       outstanding;                 // Needs to reach ROB_DEPTH
    logic [LANE_W-1:0]    rr_last;
    logic [NUM_LANES-1:0] busy_eff;
    logic                 pend_mul;
    logic                 pick_found;
    logic [LANE_W-1:0]    pick_lane;
    logic                 rob_full;
    logic                 accept;

    // A MUL strobed this cycle has not raised busy yet
    assign pend_mul = (issue_req.req.opcode == OP_ALU) && (issue_req.req.funct7 == F7_MUL);
    assign busy_eff = busy | (issue_valid & {NUM_LANES{pend_mul}});

    always_comb begin : pick_blk
        logic [LANE_W-1:0] cand;
        pick_found = 1'b0;
        pick_lane  = '0;
        cand       = '0;
        // Search starts at the lane after the last one used
        for (int k = 0; k < NUM_LANES; k++) begin
            cand = LANE_W'((int'(rr_last) + 1 + k) % NUM_LANES);
            if (!pick_found && !busy_eff[cand]) begin
                pick_found = 1'b1;
                pick_lane  = cand;
            end
        end
    end

    assign rob_full = (outstanding == (TAG_W + 1)'(ROB_DEPTH));
    assign stall    = !pick_found || rob_full;
    assign accept   = in_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_cnt     <= '0;
            outstanding <= '0;
            rr_last     <= LANE_W'(NUM_LANES - 1);     // First pick is lane 0
            issue_valid <= '0;
        end else begin
            issue_valid <= '0;
            if (accept) begin
                issue_valid[pick_lane] <= 1'b1;
                tag_cnt                <= tag_cnt + 1'b1;  // Wraps with the ROB
                rr_last                <= pick_lane;
            end
            case ({accept, retire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_req.req <= in_req;
            issue_req.tag <= tag_cnt;
        end
    end

endmodule

//--- hw/result_merge.sv
`timescale 1ns/10ps

module result_merge (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [exec_pkg::NUM_LANES-1:0] res_valid,
    input  exec_pkg::lane_res_t            res [exec_pkg::NUM_LANES],
    output logic                           out_valid,
    output exec_pkg::retire_t              out_res
);
    import exec_pkg::*;

    retire_t              rob_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] filled;
    logic [TAG_W-1:0]     head;
    logic                 head_ready;

    assign head_ready = filled[head];

    // Payload side, indexed by tag
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (res_valid[i]) begin
                rob_data[res[i].tag].alu_out      <= res[i].alu_out;
                rob_data[res[i].tag].target_pc    <= res[i].target_pc;
                rob_data[res[i].tag].branch_taken <= res[i].branch_taken;
            end
        end
        if (head_ready) begin
            out_res <= rob_data[head];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            filled    <= '0;
            head      <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= head_ready;
            if (head_ready) begin
                filled[head] <= 1'b0;
                head         <= head + 1'b1;  // Wraps with the tag counter
            end
            // Lane tags in one cycle are distinct and never the head being drained
            for (int i = 0; i < NUM_LANES; i++) begin
                if (res_valid[i]) begin
                    filled[res[i].tag] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute-cluster testbench with Verilator
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert \
        -f exec_cluster.f \
        --top-module exec_cluster_tb \
        -o exec_cluster_sim &&
    ./obj_dir/exec_cluster_sim | tee /dev/stderr |
        grep -q "Simulation finished: PASS" &&
    echo "run_sim: simulation passed" ||
    { echo "run_sim: simulation failed"; exit 1; }

//--- verif/exec_cluster_checker.sv
`timescale 1ns/10ps

module exec_cluster_checker (
    input logic                           clk,
    input logic                           reset,
    input logic                           in_valid,
    input logic                           stall,
    input logic [exec_pkg::NUM_LANES-1:0] issue_valid,
    input logic [exec_pkg::NUM_LANES-1:0] busy,
    input logic                           out_valid
);
    import exec_pkg::*;

    logic [TAG_W:0] in_flight;  // Issued but not yet retired

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            case ({|issue_valid, out_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // One lane strobed for each accepted request, none otherwise
    a_issue_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(issue_valid) && ((|issue_valid) == $past(in_valid && !stall)))
        else $error("issue_valid does not match exactly one accepted request");

    a_issue_free_lane: assert property (@(posedge clk) disable iff (reset)
        (issue_valid & busy) == '0)
        else $error("A lane was strobed while its busy was high");

    a_retire_needs_work: assert property (@(posedge clk) disable iff (reset)
        $rose(out_valid) |-> (in_flight != '0))
        else $error("out_valid rose with nothing outstanding");

endmodule

//--- verif/exec_cluster_tb.sv
`timescale 1ns/10ps

module exec_cluster_tb;
    import exec_pkg::*;

    localparam int N_DIRECTED      = 64;  // Upper bound on directed instructions
    localparam int N_RANDOM        = 2000;
    localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 10 + 200;

    logic      clk;
    logic      reset;
    logic      in_valid;
    exec_req_t in_req;
    logic      stall;
    logic      out_valid;
    retire_t   out_res;

    integer    seed;
    int        accepted_count;
    int        retired_count;
    int        error_count;
    int        rob_used;  // Accepted and not yet retired, as the dispatcher counts it
    string     test_name;
    retire_t   exp_q[$];
    string     name_q[$];

    logic [31:0] shift_amts [4] = '{32'd4, 32'd31, 32'd32, 32'd40};
    logic [2:0]  br_f3 [4]      = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE};
    logic [31:0] cmp_a [3]      = '{32'd5, 32'h8000_0000, 32'd1};  // Equal, greater, lesser
    logic [31:0] cmp_b [3]      = '{32'd5, 32'd1, 32'hFFFF_FFFF};

    exec_cluster i_exec_cluster (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .stall     (stall),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    bind exec_cluster exec_cluster_checker i_exec_cluster_checker (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .stall       (stall),
        .issue_valid (issue_valid),
        .busy        (busy),
        .out_valid   (out_valid)
    );

    always #10 clk = ~clk;

    // Expected lane result from the opcode table
    function automatic retire_t ref_exec(input exec_req_t q);
        retire_t    e;
        logic [2:0] f3;
        f3             = q.funct3;
        e.alu_out      = 32'h0;
        e.target_pc    = q.pc + q.immediate;
        e.branch_taken = 1'b0;
        if (q.opcode == OP_ALU) begin
            if (q.funct7 == F7_SUB) e.alu_out = q.operand1 - q.operand2;
            else if (q.funct7 == F7_MUL) e.alu_out = q.operand1 * q.operand2;
            else if (q.funct7 == F7_MOVRM) e.alu_out = q.rm1;
            else if (q.funct7 == F7_BASE && f3 == F3_ADD) e.alu_out = q.operand1 + q.operand2;
            else if (q.funct7 == F7_BASE && f3 == F3_AND) e.alu_out = q.operand1 & q.operand2;
            else if (q.funct7 == F7_BASE && f3 == F3_OR) e.alu_out = q.operand1 | q.operand2;
        end else if (q.opcode == OP_ALUI) begin
            if (f3 == F3_ADDI) e.alu_out = q.operand1 + q.immediate;
            else if (f3 == F3_SLLI && q.immediate < 32) e.alu_out = q.operand1 << q.immediate[4:0];
            else if (f3 == F3_SRLI && q.immediate < 32) e.alu_out = q.operand1 >> q.immediate[4:0];
        end else if (q.opcode == OP_AUIPC) begin
            e.alu_out = q.pc + q.immediate;
        end else if (q.opcode == OP_LUI) begin
            e.alu_out = q.immediate;
        end else if (q.opcode == OP_BRANCH) begin
            if (f3 == F3_BEQ || f3 == F3_BNE || f3 == F3_BLT || f3 == F3_BGE) begin
                e.alu_out = q.operand1 - q.operand2;
                if (f3 == F3_BEQ) e.branch_taken = (q.operand1 == q.operand2);
                else if (f3 == F3_BNE) e.branch_taken = (q.operand1 != q.operand2);
                else if (f3 == F3_BLT) e.branch_taken = (q.operand1 < q.operand2);
                else e.branch_taken = !(q.operand1 < q.operand2);
            end
        end else if (q.opcode == OP_JUMP) begin
            e.branch_taken = 1'b1;
        end else if (q.opcode == OP_LOAD || q.opcode == OP_STORE) begin
            e.alu_out = q.operand1 + q.immediate;  // Effective address
        end else if (q.opcode == OP_SYSTEM && f3 == F3_MOVRM) begin
            e.alu_out = q.operand1;
        end
        return e;
    endfunction

    function automatic exec_req_t make_req(input logic [6:0] opcode, input logic [2:0] f3,
            input logic [6:0] f7, input logic [31:0] op1, input logic [31:0] op2,
            input logic [31:0] imm);
        exec_req_t q;
        q.opcode    = opcode;
        q.funct3    = f3;
        q.funct7    = f7;
        q.operand1  = op1;
        q.operand2  = op2;
        q.immediate = imm;
        q.pc        = 32'h0000_1000 + 32'(accepted_count << 2);
        q.rm1       = ~q.pc ^ 32'h5A5A_0000;
        return q;
    endfunction

    function automatic exec_req_t random_req();
        exec_req_t q;
        int        pick;
        pick       = int'({$random(seed)} % 32'd12);
        q.funct3   = 3'($random(seed));
        q.operand1 = $random(seed);
        q.operand2 = ({$random(seed)} % 32'd4 == 0) ? q.operand1 : $random(seed);
        q.immediate = ({$random(seed)} % 32'd2 == 0) ? {$random(seed)} % 32'd40 : $random(seed);
        q.pc       = $random(seed);
        q.rm1      = $random(seed);
        case ({$random(seed)} % 32'd5)
            0: q.funct7 = F7_BASE;
            1: q.funct7 = F7_SUB;
            2: q.funct7 = F7_MUL;
            3: q.funct7 = F7_MOVRM;
            default: q.funct7 = 7'($random(seed));
        endcase
        case (pick)
            0, 1: q.opcode = OP_ALU;
            2: q.opcode = OP_ALUI;
            3: q.opcode = OP_AUIPC;
            4: q.opcode = OP_LUI;
            5: q.opcode = OP_BRANCH;
            6: q.opcode = OP_JUMP;
            7: q.opcode = OP_LOAD;
            8: q.opcode = OP_STORE;
            9: q.opcode = OP_SYSTEM;
            10: begin
                q.opcode = OP_ALU;
                q.funct7 = F7_MUL;  // Extra multiplies for out-of-order completion
            end
            default: q.opcode = 7'($random(seed));
        endcase
        return q;
    endfunction

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_retire(input string name, input retire_t exp, input retire_t act);
        if (act.alu_out !== exp.alu_out || act.target_pc !== exp.target_pc
                || act.branch_taken !== exp.branch_taken) begin
            stop_on_error($sformatf(
                "Error: %s expected alu_out=%h target_pc=%h taken=%b, actual %h %h %b",
                name, exp.alu_out, exp.target_pc, exp.branch_taken,
                act.alu_out, act.target_pc, act.branch_taken));
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s stall expected %b, actual %b", name, exp, act));
        end
    endtask

    // Called at posedge + 2 ns and returns at the same phase after acceptance
    task automatic send(input exec_req_t req);
        in_req   = req;
        in_valid = 1'b1;
        while (stall) begin  // Hold until the dispatcher takes it
            @(posedge clk);
            #2;
        end
        exp_q.push_back(ref_exec(req));
        name_q.push_back(test_name);
        accepted_count++;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("Error: out_valid with no accepted request outstanding");
            end else begin
                retired_count++;
                check_retire(name_q.pop_front(), exp_q.pop_front(), out_res);
            end
        end
    end

    // Stall rule checked every cycle, then the count follows the coming edge
    always @(negedge clk) begin
        if (reset) begin
            rob_used = 0;
        end else begin
            check_stall(test_name, (&i_exec_cluster.busy) || (rob_used == ROB_DEPTH), stall);
            if (in_valid && !stall) rob_used++;
            if (out_valid) rob_used--;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("Error: watchdog expired, results stopped arriving");
    end

    initial begin
        int gap;
        seed           = 46198;
        clk            = 1'b0;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_req         = '0;
        accepted_count = 0;
        retired_count  = 0;
        error_count    = 0;
        test_name      = "reset_state";
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        check_stall(test_name, 1'b0, stall);
        if (out_valid !== 1'b0) stop_on_error("Error: out_valid high right after reset");
        send(make_req(OP_ALU, F3_ADD, F7_BASE, 32'h7FFF_FFFF, 32'h1, 32'h0));

        test_name = "reg_imm_ops";
        send(make_req(OP_ALU, F3_ADD, F7_SUB, 32'h5, 32'h9, 32'h0));
        send(make_req(OP_ALU, F3_AND, F7_BASE, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0));
        send(make_req(OP_ALU, F3_OR, F7_BASE, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h0));
        send(make_req(OP_ALU, 3'b000, F7_MOVRM, 32'h1, 32'h2, 32'h0));
        send(make_req(OP_ALUI, F3_ADDI, F7_BASE, 32'h1000, 32'h0, 32'hFFFF_FFF0));
        for (int i = 0; i < 4; i++) begin
            send(make_req(OP_ALUI, F3_SLLI, F7_BASE, 32'h8000_0001, 32'h0, shift_amts[i]));
            send(make_req(OP_ALUI, F3_SRLI, F7_BASE, 32'h8000_0001, 32'h0, shift_amts[i]));
        end

        test_name = "upper_mem_sys";
        send(make_req(OP_AUIPC, 3'b000, F7_BASE, 32'h0, 32'h0, 32'h0001_2000));
        send(make_req(OP_LUI, 3'b000, F7_BASE, 32'h0, 32'h0, 32'hABCD_E000));
        send(make_req(OP_LOAD, 3'b010, F7_BASE, 32'h2000, 32'h0, 32'h10));
        send(make_req(OP_STORE, 3'b010, F7_BASE, 32'h2000, 32'h77, 32'hFFFF_FFFC));
        send(make_req(OP_SYSTEM, F3_IRET, F7_BASE, 32'h1234_5678, 32'h0, 32'h0));
        send(make_req(OP_SYSTEM, F3_MOVRM, F7_BASE, 32'h1234_5678, 32'h0, 32'h0));
        send(make_req(OP_SYSTEM, F3_TLBWRITE, F7_BASE, 32'h1234_5678, 32'h9, 32'h0));
        send(make_req(OP_SYSTEM, 3'b010, F7_BASE, 32'h1234_5678, 32'h0, 32'h0));

        test_name = "branches";
        for (int b = 0; b < 4; b++) begin
            for (int c = 0; c < 3; c++) begin
                send(make_req(OP_BRANCH, br_f3[b], F7_BASE, cmp_a[c], cmp_b[c], 32'h40));
            end
        end
        send(make_req(OP_JUMP, 3'b000, F7_BASE, 32'h5, 32'h5, 32'hFFFF_FF00));
        send(make_req(OP_JUMP, 3'b111, F7_BASE, 32'h1, 32'h2, 32'h100));
        send(make_req(OP_BRANCH, 3'b010, F7_BASE, 32'h5, 32'h5, 32'h40));
        send(make_req(OP_BRANCH, 3'b011, F7_BASE, 32'h1, 32'h9, 32'h40));
        send(make_req(7'b1111111, 3'b000, F7_BASE, 32'h1, 32'h9, 32'h40));

        test_name = "mul_burst";  // MULs issued back to back finish after later ADDs
        for (int i = 0; i < 16; i++) begin
            send(make_req(OP_ALU, F3_ADD, (i % 2 == 0) ? F7_MUL : F7_BASE,
                          $random(seed), $random(seed), 32'h8));
        end

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            gap = int'({$random(seed)} % 32'd4);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            send(random_req());
        end

        wait (retired_count == accepted_count);
        repeat (20) @(posedge clk);  // Catch any stray retire
        if (error_count == 0 && retired_count == accepted_count && exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_on_error($sformatf("Error: %0d results retired for %0d accepted requests",
                                    retired_count, accepted_count));
        end
    end

endmodule
